//--- Bender.yml
package:
  name: dcache

sources:
  - files:
      - rtl/dcache_pkg.sv
      - rtl/dcache_tag_store.sv
      - rtl/dcache_data_store.sv
      - rtl/dcache_ctrl.sv
      - rtl/dcache_cfg_regs.sv
      - rtl/dcache_top.sv
  - target: test
    files:
      - dv/dcache_chk.sv
      - dv/dcache_tb.sv

//--- dv/dcache_chk.sv
`default_nettype none

module dcache_chk import dcache_pkg::*; (
   input  wire logic       clk,
   input  wire logic       rst,
   input  wire logic       cpu_req_i,
   input  wire logic       cpu_ack_o,
   input  wire logic       mem_req_o,
   input  wire mem_req_t   mem_o,
   input  wire logic       mem_ack_i
);

   // Failed properties so far, polled by the testbench
   int unsigned fail_cnt = 0;

   // CPU ack only answers a request seen the cycle before
   ack_has_req: assert property (@(posedge clk) disable iff (rst)
      cpu_ack_o |-> $past(cpu_req_i))
   else begin
      fail_cnt++;
      $error("cpu_ack_o high without cpu_req_i in the previous cycle");
   end

   // Memory request fields frozen until memory answers
   mem_stable: assert property (@(posedge clk) disable iff (rst)
      (mem_req_o && !mem_ack_i) |=> $stable(mem_o))
   else begin
      fail_cnt++;
      $error("mem_o changed while waiting for mem_ack_i");
   end

   // Request drops only after the ack was seen
   mem_req_held: assert property (@(posedge clk) disable iff (rst)
      $fell(mem_req_o) |-> $past(mem_ack_i))
   else begin
      fail_cnt++;
      $error("mem_req_o fell before mem_ack_i");
   end

endmodule

bind dcache_top dcache_chk u_chk (
   .clk       (clk),
   .rst       (rst),
   .cpu_req_i (cpu_req_i),
   .cpu_ack_o (cpu_ack_o),
   .mem_req_o (mem_req_o),
   .mem_o     (mem_o),
   .mem_ack_i (mem_ack_i)
);

`default_nettype wire

//--- dv/dcache_tb.sv
`default_nettype none

module dcache_tb import dcache_pkg::*; ();

   localparam int DRIVE_DLY   = 2;
   localparam int TIMEOUT     = 200;
   localparam int MODEL_WORDS = 1024;

   typedef enum {M_IDLE, M_DELAY, M_ACK} mem_state_e;

   logic                    clk;
   logic                    rst;
   logic                    cpu_req_i;
   cpu_req_t                cpu_i;
   logic                    cpu_ack_o;
   logic [DATA_W-1:0]       cpu_rdata_o;
   logic                    mem_req_o;
   mem_req_t                mem_o;
   logic                    mem_ack_i;
   logic [DATA_W-1:0]       mem_rdata_i;
   logic                    cfg_req_i;
   logic                    cfg_we_i;
   logic [CFG_ADDR_W-1:0]   cfg_addr_i;
   cfg_wdata_u              cfg_wdata_i;
   logic                    cfg_ack_o;
   logic [DATA_W-1:0]       cfg_rdata_o;

   // Memory model contents and transaction log
   logic [DATA_W-1:0]       model_mem [MODEL_WORDS];
   logic [31:0]             rng;
   mem_state_e              mst;
   int                      delay_cnt;
   mem_req_t                txn;
   logic [ADDR_W-1:0]       txn_addr;
   int                      mem_writes = 0;
   logic [ADDR_W-1:0]       read_addrs [$];
   logic [ADDR_W-1:0]       last_wr_addr;
   logic [BSEL_W-1:0]       last_wr_bsel;

   // Compare process bookkeeping
   string                   test_name = "reset";
   logic                    ack_q;
   int                      reads_issued = 0;
   int                      reads_checked = 0;

   dcache_top uut (
      .clk         (clk),
      .rst         (rst),
      .cpu_req_i   (cpu_req_i),
      .cpu_i       (cpu_i),
      .cpu_ack_o   (cpu_ack_o),
      .cpu_rdata_o (cpu_rdata_o),
      .mem_req_o   (mem_req_o),
      .mem_o       (mem_o),
      .mem_ack_i   (mem_ack_i),
      .mem_rdata_i (mem_rdata_i),
      .cfg_req_i   (cfg_req_i),
      .cfg_we_i    (cfg_we_i),
      .cfg_addr_i  (cfg_addr_i),
      .cfg_wdata_i (cfg_wdata_i),
      .cfg_ack_o   (cfg_ack_o),
      .cfg_rdata_o (cfg_rdata_o)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Expected read word taken straight from the model array
   function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] addr);
      return model_mem[addr[11:2]];
   endfunction

   // Byte lanes enabled in bsel take the new data
   function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
                                                     input logic [DATA_W-1:0] new_w,
                                                     input logic [BSEL_W-1:0] bsel);
      logic [DATA_W-1:0] res;
      res = old_w;
      for (int b = 0; b < BSEL_W; b++) begin
         if (bsel[b])
            res[8*b +: 8] = new_w[8*b +: 8];
      end
      return res;
   endfunction

   function automatic logic [ADDR_W-1:0] make_addr(input int tag, input int index,
                                                   input int word);
      cache_addr_t a;
      a       = '0;
      a.tag   = TAG_W'(tag);
      a.index = INDEX_W'(index);
      a.word  = WORD_OFS_W'(word);
      return a;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check(input string what, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (expected !== actual)
         abort_run($sformatf("FAILED %s, %s: expected %h, actual %h",
                             test_name, what, expected, actual));
   endtask

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Memory model answers each request after 1 to 4 cycles
   always @(posedge clk) begin
      #DRIVE_DLY;
      if (rst) begin
         mem_ack_i = 1'b0;
         mst       = M_IDLE;
      end else begin
         case (mst)
            M_IDLE: begin
               if (mem_req_o) begin
                  txn       = mem_o;
                  rng       = xorshift(rng);
                  delay_cnt = 1 + (rng % 4);
                  mst       = M_DELAY;
               end
            end
            M_DELAY: begin
               delay_cnt--;
               if (delay_cnt == 0) begin
                  txn_addr = txn.addr;
                  if (txn_addr[ADDR_W-1:12] != '0)
                     abort_run("Memory access outside the model address range");
                  // Writes update byte by byte, reads return the stored word
                  if (txn.we) begin
                     model_mem[txn_addr[11:2]] = merge_bytes(model_mem[txn_addr[11:2]],
                                                             txn.wdata, txn.bsel);
                     mem_writes++;
                     last_wr_addr = txn_addr;
                     last_wr_bsel = txn.bsel;
                  end else begin
                     mem_rdata_i = model_mem[txn_addr[11:2]];
                     read_addrs.push_back(txn_addr);
                  end
                  mem_ack_i = 1'b1;
                  mst       = M_ACK;
               end
            end
            default: begin
               // Hold ack until the request is gone
               if (!mem_req_o) begin
                  mem_ack_i = 1'b0;
                  mst       = M_IDLE;
               end
            end
         endcase
      end
   end

   // Compare every read at its rising ack
   always @(negedge clk) begin
      if (rst !== 1'b1 && cpu_ack_o === 1'b1 && !ack_q && !cpu_i.we) begin
         check("read data", expected_word(cpu_i.addr), cpu_rdata_o);
         reads_checked++;
      end
      ack_q = cpu_ack_o;
      if (uut.u_chk.fail_cnt != 0)
         abort_run("A handshake assertion on the DUT ports failed");
   end

   // One four-phase CPU transfer
   // Latency counts edges after the request was sampled
   task automatic cpu_access(input logic [ADDR_W-1:0] addr, input logic we,
                             input logic [DATA_W-1:0] wdata, input logic [BSEL_W-1:0] bsel,
                             output int lat);
      int cycles;
      @(posedge clk);
      #DRIVE_DLY;
      cpu_i.addr  = addr;
      cpu_i.we    = we;
      cpu_i.wdata = wdata;
      cpu_i.bsel  = bsel;
      cpu_req_i   = 1'b1;
      if (!we)
         reads_issued++;
      cycles = 0;
      while (!cpu_ack_o) begin
         @(posedge clk);
         #DRIVE_DLY;
         cycles++;
         if (cycles > TIMEOUT)
            abort_run("Timeout waiting for cpu_ack_o to rise");
      end
      lat       = cycles - 1;
      cpu_req_i = 1'b0;
      cycles    = 0;
      while (cpu_ack_o) begin
         @(posedge clk);
         #DRIVE_DLY;
         cycles++;
         if (cycles > TIMEOUT)
            abort_run("Timeout waiting for cpu_ack_o to fall");
      end
   endtask

   task automatic cfg_access(input logic we, input logic [CFG_ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] wdata,
                             output logic [DATA_W-1:0] rdata);
      int cycles;
      @(posedge clk);
      #DRIVE_DLY;
      cfg_we_i    = we;
      cfg_addr_i  = addr;
      cfg_wdata_i = wdata;
      cfg_req_i   = 1'b1;
      cycles      = 0;
      while (!cfg_ack_o) begin
         @(posedge clk);
         #DRIVE_DLY;
         cycles++;
         if (cycles > TIMEOUT)
            abort_run("Timeout waiting for cfg_ack_o to rise");
      end
      rdata     = cfg_rdata_o;
      cfg_req_i = 1'b0;
      cycles    = 0;
      while (cfg_ack_o) begin
         @(posedge clk);
         #DRIVE_DLY;
         cycles++;
         if (cycles > TIMEOUT)
            abort_run("Timeout waiting for cfg_ack_o to fall");
      end
   endtask

   // Read one word, then check the memory traffic it caused
   task automatic read_expect(input logic [ADDR_W-1:0] addr, input int exp_reads,
                              output int lat);
      int writes_before;
      read_addrs.delete();
      writes_before = mem_writes;
      cpu_access(addr, 1'b0, '0, '0, lat);
      check("memory reads", exp_reads, read_addrs.size());
      check("memory writes", 0, mem_writes - writes_before);
      for (int i = 0; i < read_addrs.size(); i++) begin
         // Bypass reads the word itself, refill walks the line from word 0
         if (exp_reads == 1)
            check("bypass address", addr, read_addrs[i]);
         else
            check("refill address", {addr[ADDR_W-1:4], 4'(4 * i)}, read_addrs[i]);
      end
   endtask

   // Store one word and check the single write-through
   task automatic write_expect(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                               input logic [BSEL_W-1:0] bsel);
      logic [DATA_W-1:0] old_w;
      int writes_before;
      int lat;
      old_w = expected_word(addr);
      read_addrs.delete();
      writes_before = mem_writes;
      cpu_access(addr, 1'b1, wdata, bsel, lat);
      check("memory writes", 1, mem_writes - writes_before);
      check("memory reads", 0, read_addrs.size());
      check("write address", addr, last_wr_addr);
      check("write bsel", bsel, last_wr_bsel);
      check("merged memory word", merge_bytes(old_w, wdata, bsel), expected_word(addr));
   endtask

   initial begin
      logic [DATA_W-1:0] rd;
      int lat;
      rst         = 1'b1;
      cpu_req_i   = 1'b0;
      cpu_i       = '0;
      mem_ack_i   = 1'b0;
      mem_rdata_i = '0;
      cfg_req_i   = 1'b0;
      cfg_we_i    = 1'b0;
      cfg_addr_i  = '0;
      cfg_wdata_i = '0;
      ack_q       = 1'b0;
      // Model memory filled from the xorshift stream
      rng = 32'hc0aa;
      for (int i = 0; i < MODEL_WORDS; i++) begin
         rng          = xorshift(rng);
         model_mem[i] = rng;
      end
      repeat (16) @(posedge clk);
      #DRIVE_DLY;
      rst = 1'b0;

      test_name = "enable";
      cfg_access(1'b1, CFG_ADDR_W'(CFG_CTRL_ADDR), 32'h1, rd);

      test_name = "read miss then hit";
      read_expect(make_addr(1, 3, 2), 4, lat);
      read_expect(make_addr(1, 3, 0), 0, lat);
      check("hit latency", 2, lat);

      test_name = "write-through";
      write_expect(make_addr(1, 3, 1), 32'ha5c3_5a3c, 4'b0110);
      read_expect(make_addr(1, 3, 1), 0, lat);
      check("hit latency", 2, lat);

      test_name = "store miss";
      write_expect(make_addr(2, 5, 3), 32'h1234_5678, 4'b1111);
      read_expect(make_addr(2, 5, 3), 4, lat);

      // Tags A=3, B=4, C=5 all map to set 7
      test_name = "LRU replacement";
      read_expect(make_addr(3, 7, 0), 4, lat);
      read_expect(make_addr(4, 7, 1), 4, lat);
      read_expect(make_addr(3, 7, 2), 0, lat);
      read_expect(make_addr(5, 7, 3), 4, lat);
      read_expect(make_addr(3, 7, 1), 0, lat);
      read_expect(make_addr(4, 7, 2), 4, lat);

      test_name = "invalidate";
      cfg_access(1'b1, CFG_ADDR_W'(CFG_INVAL_ADDR), make_addr(3, 7, 0), rd);
      read_expect(make_addr(3, 7, 0), 4, lat);
      read_expect(make_addr(4, 7, 0), 4, lat);
      cfg_access(1'b0, CFG_ADDR_W'(CFG_CTRL_ADDR), '0, rd);
      check("enable readback", 1, rd);

      test_name = "bypass";
      cfg_access(1'b1, CFG_ADDR_W'(CFG_CTRL_ADDR), 32'h0, rd);
      cfg_access(1'b0, CFG_ADDR_W'(CFG_CTRL_ADDR), '0, rd);
      check("enable readback", 0, rd);
      read_expect(make_addr(6, 9, 1), 1, lat);
      read_expect(make_addr(6, 9, 1), 1, lat);
      // A line still held in the cache goes to memory too
      read_expect(make_addr(3, 7, 0), 1, lat);

      test_name = "summary";
      check("reads compared", reads_issued, reads_checked);
      if (uut.u_chk.fail_cnt == 0) begin
         $display("Simulation finished: PASS");
         $finish;
      end else begin
         abort_run("A handshake assertion on the DUT ports failed");
      end
   end

endmodule

`default_nettype wire

//--- rtl/dcache_cfg_regs.sv
`default_nettype none

module dcache_cfg_regs import dcache_pkg::*; (
   input  wire logic                    clk,
   input  wire logic                    rst,
   input  wire logic                    cfg_req_i,
   input  wire logic                    cfg_we_i,
   input  wire logic [CFG_ADDR_W-1:0]   cfg_addr_i,
   input  wire cfg_wdata_u              cfg_wdata_i,
   output logic                         cfg_ack_o,
   output logic [DATA_W-1:0]            cfg_rdata_o,
   output logic                         enable_o,
   output logic                         inval_req_o,
   output logic [INDEX_W-1:0]           inval_index_o,
   input  wire logic                    inval_ack_i
);

   logic is_ctrl;
   logic accept;

   assign is_ctrl = (cfg_addr_i == CFG_ADDR_W'(CFG_CTRL_ADDR));

   // New transfer only when both handshakes are back at rest
   assign accept = cfg_req_i && !cfg_ack_o && !inval_req_o && !inval_ack_i;

   always_ff @(posedge clk) begin
      if (rst) begin
         cfg_ack_o   <= 1'b0;
         enable_o    <= 1'b0;
         inval_req_o <= 1'b0;
      end else begin
         if (accept) begin
            if (cfg_we_i && cfg_addr_i == CFG_ADDR_W'(CFG_INVAL_ADDR)) begin
               // Bus ack waits for the cache side
               inval_req_o <= 1'b1;
            end else begin
               cfg_ack_o <= 1'b1;
               if (cfg_we_i && is_ctrl)
                  enable_o <= cfg_wdata_i.ctrl.enable;
            end
         end else if (inval_req_o && inval_ack_i) begin
            inval_req_o <= 1'b0;
            cfg_ack_o   <= 1'b1;
         end else if (cfg_ack_o && !cfg_req_i) begin
            cfg_ack_o <= 1'b0;
         end
      end
   end

   // Invalidate index and read data
   always_ff @(posedge clk) begin
      if (accept && cfg_we_i && !is_ctrl)
         inval_index_o <= cfg_wdata_i.inval.index;
      if (accept && !cfg_we_i)
         cfg_rdata_o <= is_ctrl ? DATA_W'(enable_o) : '0;
   end

endmodule

`default_nettype wire

//--- rtl/dcache_ctrl.sv
`default_nettype none

module dcache_ctrl import dcache_pkg::*; (
   input  wire logic                    clk,
   input  wire logic                    rst,
   // CPU side
   input  wire logic                    cpu_req_i,
   input  wire cpu_req_t                cpu_i,
   output logic                         cpu_ack_o,
   output logic [DATA_W-1:0]            cpu_rdata_o,
   // Memory side
   output logic                         mem_req_o,
   output mem_req_t                     mem_o,
   input  wire logic                    mem_ack_i,
   input  wire logic [DATA_W-1:0]       mem_rdata_i,
   // Configuration
   input  wire logic                    enable_i,
   input  wire logic                    inval_req_i,
   input  wire logic [INDEX_W-1:0]      inval_index_i,
   output logic                         inval_ack_o,
   // Tag store
   input  wire logic                    hit_i,
   input  wire logic                    hit_way_i,
   input  wire logic                    victim_way_i,
   output logic                         tag_wr_en_o,
   output logic [INDEX_W-1:0]           tag_wr_index_o,
   output logic                         tag_wr_way_o,
   output tag_entry_t                   tag_wr_entry_o,
   output logic                         tag_inval_o,
   output logic                         lru_touch_o,
   output logic                         lru_way_o,
   // Data store
   output logic                         ds_wr_en_o,
   output logic                         ds_wr_way_o,
   output logic [WORD_OFS_W-1:0]        ds_wr_word_o,
   output logic [DATA_W-1:0]            ds_wr_data_o,
   output logic [BSEL_W-1:0]            ds_wr_bsel_o,
   input  wire logic [DATA_W-1:0]       store_rdata_i
);

   typedef enum logic [2:0] {
      S_IDLE, S_LOOKUP, S_COMPARE, S_REFILL_REQ,
      S_REFILL_WAIT, S_WRITE, S_BYPASS, S_DONE
   } state_e;

   state_e                  state_q;
   logic [WORD_OFS_W-1:0]   word_q;
   logic                    victim_q;
   logic                    ack_seen_q;
   logic [INDEX_W:0]        init_cnt_q;
   logic                    init_done;
   logic                    refill;
   logic                    last_word;
   logic                    take_inval;

   // Tag store clears one set per cycle after reset, wait for it
   assign init_done  = init_cnt_q[INDEX_W];
   assign refill     = (state_q == S_REFILL_REQ) || (state_q == S_REFILL_WAIT);
   assign last_word  = (word_q == WORD_OFS_W'(WORDS_PER_LINE - 1));
   // Invalidate wins over a CPU request in idle
   assign take_inval = (state_q == S_IDLE) && init_done && inval_req_i && !inval_ack_o;

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q     <= S_IDLE;
         cpu_ack_o   <= 1'b0;
         inval_ack_o <= 1'b0;
         ack_seen_q  <= 1'b0;
         word_q      <= '0;
         init_cnt_q  <= '0;
      end else begin
         if (!init_done)
            init_cnt_q <= init_cnt_q + 1'b1;
         // Invalidate handshake
         if (take_inval)
            inval_ack_o <= 1'b1;
         else if (inval_ack_o && !inval_req_i)
            inval_ack_o <= 1'b0;

         case (state_q)
            S_IDLE: begin
               if (!take_inval && init_done && cpu_req_i)
                  state_q <= enable_i ? S_LOOKUP : S_BYPASS;
            end
            // Memories read the set in this cycle
            S_LOOKUP: state_q <= S_COMPARE;
            S_COMPARE: begin
               if (cpu_i.we) begin
                  state_q <= S_WRITE;
               end else if (hit_i) begin
                  cpu_ack_o <= 1'b1;
                  state_q   <= S_DONE;
               end else begin
                  word_q  <= '0;
                  state_q <= S_REFILL_REQ;
               end
            end
            S_REFILL_REQ: begin
               if (mem_ack_i)
                  state_q <= S_REFILL_WAIT;
            end
            S_REFILL_WAIT: begin
               // Next word only once memory drops its ack
               if (!mem_ack_i) begin
                  if (last_word) begin
                     state_q <= S_LOOKUP;
                  end else begin
                     word_q  <= word_q + 1'b1;
                     state_q <= S_REFILL_REQ;
                  end
               end
            end
            // Single memory transfer for write-through and bypass
            S_WRITE, S_BYPASS: begin
               if (mem_ack_i) begin
                  ack_seen_q <= 1'b1;
               end else if (ack_seen_q) begin
                  ack_seen_q <= 1'b0;
                  cpu_ack_o  <= 1'b1;
                  state_q    <= S_DONE;
               end
            end
            // Hold ack until the CPU lets go
            S_DONE: begin
               if (!cpu_req_i) begin
                  cpu_ack_o <= 1'b0;
                  state_q   <= S_IDLE;
               end
            end
            default: state_q <= S_IDLE;
         endcase
      end
   end

   // Victim and read data
   always_ff @(posedge clk) begin
      if (state_q == S_COMPARE) begin
         victim_q    <= victim_way_i;
         cpu_rdata_o <= store_rdata_i;
      end
      if (state_q == S_BYPASS && mem_ack_i)
         cpu_rdata_o <= mem_rdata_i;
   end

   always_comb begin
      mem_o = cpu_i;
      // Refill reads whole words of the line
      if (refill) begin
         mem_o.addr.word = word_q;
         mem_o.addr.boff = '0;
         mem_o.we        = 1'b0;
         mem_o.bsel      = '1;
      end
      case (state_q)
         S_REFILL_REQ:      mem_req_o = 1'b1;
         S_WRITE, S_BYPASS: mem_req_o = !ack_seen_q;
         default:           mem_req_o = 1'b0;
      endcase
   end

   // Tag store controls
   assign tag_inval_o    = take_inval;
   assign tag_wr_index_o = (state_q == S_IDLE) ? inval_index_i : cpu_i.addr.index;
   assign tag_wr_en_o    = (state_q == S_REFILL_WAIT) && !mem_ack_i && last_word;
   assign tag_wr_way_o   = victim_q;
   assign tag_wr_entry_o = '{valid: 1'b1, tag: cpu_i.addr.tag};
   assign lru_touch_o    = (state_q == S_COMPARE) && hit_i;
   assign lru_way_o      = hit_way_i;

   // Data store writes, store hit merges, refill writes full words
   assign ds_wr_en_o   = (state_q == S_COMPARE) ? (cpu_i.we && hit_i) :
                         (state_q == S_REFILL_REQ) && mem_ack_i;
   assign ds_wr_way_o  = refill ? victim_q : hit_way_i;
   assign ds_wr_word_o = refill ? word_q : cpu_i.addr.word;
   assign ds_wr_data_o = refill ? mem_rdata_i : cpu_i.wdata;
   assign ds_wr_bsel_o = refill ? {BSEL_W{1'b1}} : cpu_i.bsel;

endmodule

`default_nettype wire

//--- rtl/dcache_data_store.sv
`default_nettype none

module dcache_data_store import dcache_pkg::*; (
   input  wire logic                    clk,
   input  wire logic [INDEX_W-1:0]      rd_index_i,
   input  wire logic [WORD_OFS_W-1:0]   rd_word_i,
   input  wire logic                    rd_way_i,
   input  wire logic                    wr_en_i,
   input  wire logic                    wr_way_i,
   input  wire logic [INDEX_W-1:0]      wr_index_i,
   input  wire logic [WORD_OFS_W-1:0]   wr_word_i,
   input  wire logic [DATA_W-1:0]       wr_data_i,
   input  wire logic [BSEL_W-1:0]       wr_bsel_i,
   output logic [DATA_W-1:0]            rdata_o
);

   localparam int unsigned DEPTH = NUM_SETS * WORDS_PER_LINE;

   // One word memory per way, addressed by set and word
   logic [DATA_W-1:0]                  mem [NUM_WAYS][DEPTH];
   logic [DATA_W-1:0]                  rd_q [NUM_WAYS];
   logic [INDEX_W+WORD_OFS_W-1:0]      rd_addr;
   logic [INDEX_W+WORD_OFS_W-1:0]      wr_addr;

   assign rd_addr = {rd_index_i, rd_word_i};
   assign wr_addr = {wr_index_i, wr_word_i};

   always_ff @(posedge clk) begin
      // Only enabled byte lanes change
      if (wr_en_i) begin
         for (int b = 0; b < BSEL_W; b++) begin
            if (wr_bsel_i[b])
               mem[wr_way_i][wr_addr][8*b +: 8] <= wr_data_i[8*b +: 8];
         end
      end
      // Both ways read every cycle
      for (int w = 0; w < NUM_WAYS; w++) begin
         rd_q[w] <= mem[w][rd_addr];
      end
   end

   // Way chosen after the read, once the hit way is known
   assign rdata_o = rd_q[rd_way_i];

endmodule

`default_nettype wire

//--- rtl/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

   // Bus widths
   localparam int unsigned ADDR_W = 32;
   localparam int unsigned DATA_W = 32;
   localparam int unsigned BSEL_W = 4;

   // Cache geometry, two ways of 16 sets with four-word lines
   localparam int unsigned WORD_OFS_W = 2;
   localparam int unsigned WORDS_PER_LINE = 4;
   localparam int unsigned INDEX_W = 4;
   localparam int unsigned NUM_SETS = 2 ** INDEX_W;
   localparam int unsigned TAG_W = 24;
   localparam int unsigned NUM_WAYS = 2;

   // Configuration register map
   localparam int unsigned CFG_ADDR_W = 2;
   localparam int unsigned CFG_CTRL_ADDR = 0;
   localparam int unsigned CFG_INVAL_ADDR = 1;

   // Byte address split into cache fields
   typedef struct packed {
      logic [TAG_W-1:0]                              tag;
      logic [INDEX_W-1:0]                            index;
      logic [WORD_OFS_W-1:0]                         word;
      logic [ADDR_W-TAG_W-INDEX_W-WORD_OFS_W-1:0]    boff;
   } cache_addr_t;

   typedef struct packed {
      cache_addr_t         addr;
      logic                we;
      logic [DATA_W-1:0]   wdata;
      logic [BSEL_W-1:0]   bsel;
   } cpu_req_t;

   // Memory transactions carry the same fields as the CPU request
   typedef cpu_req_t mem_req_t;

   typedef struct packed {
      logic               valid;
      logic [TAG_W-1:0]   tag;
   } tag_entry_t;

   // Control register layout, enable in bit 0
   typedef struct packed {
      logic [DATA_W-2:0]   rsvd;
      logic                enable;
   } cfg_ctrl_t;

   // One write word, read as control or as invalidate address
   typedef union packed {
      cfg_ctrl_t     ctrl;
      cache_addr_t   inval;
   } cfg_wdata_u;

endpackage

`default_nettype wire

//--- rtl/dcache_tag_store.sv
`default_nettype none

module dcache_tag_store import dcache_pkg::*; (
   input  wire logic                 clk,
   input  wire logic                 rst,
   input  wire logic [INDEX_W-1:0]   rd_index_i,
   input  wire logic                 wr_en_i,
   input  wire logic [INDEX_W-1:0]   wr_index_i,
   input  wire logic                 wr_way_i,
   input  wire tag_entry_t           wr_entry_i,
   input  wire logic                 inval_i,
   input  wire logic                 lru_touch_i,
   input  wire logic                 lru_way_i,
   input  wire logic [TAG_W-1:0]     lookup_tag_i,
   output logic                      hit_o,
   output logic                      hit_way_o,
   output logic                      victim_way_o
);

   // Tag and valid per way, one LRU bit per set naming the way to replace
   tag_entry_t           tags [NUM_WAYS][NUM_SETS];
   logic [NUM_SETS-1:0]  lru_q;

   // Registered read of the addressed set
   tag_entry_t           ent_q [NUM_WAYS];
   logic                 lru_rd_q;
   logic [NUM_WAYS-1:0]  way_hit;

   // Valid bit clear walk after reset
   logic                 clr_busy_q;
   logic [INDEX_W-1:0]   clr_idx_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         clr_busy_q <= 1'b1;
         clr_idx_q  <= '0;
      end else if (clr_busy_q) begin
         clr_idx_q <= clr_idx_q + 1'b1;
         if (clr_idx_q == INDEX_W'(NUM_SETS - 1))
            clr_busy_q <= 1'b0;
      end
   end

   // Tag memory, walk has priority over functional writes
   always_ff @(posedge clk) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
         ent_q[w] <= tags[w][rd_index_i];
      end
      if (clr_busy_q) begin
         for (int w = 0; w < NUM_WAYS; w++) begin
            tags[w][clr_idx_q] <= '0;
         end
      end else if (inval_i) begin
         for (int w = 0; w < NUM_WAYS; w++) begin
            tags[w][wr_index_i] <= '0;
         end
      end else if (wr_en_i) begin
         tags[wr_way_i][wr_index_i] <= wr_entry_i;
      end
   end

   // LRU bits
   always_ff @(posedge clk) begin
      if (rst) begin
         lru_q <= '0;
      end else if (inval_i) begin
         lru_q[wr_index_i] <= 1'b0;
      end else if (lru_touch_i) begin
         // Point at the way that was not used
         lru_q[wr_index_i] <= ~lru_way_i;
      end
   end

   always_ff @(posedge clk) begin
      lru_rd_q <= lru_q[rd_index_i];
   end

   // Compare both ways on the registered entries
   always_comb begin
      for (int w = 0; w < NUM_WAYS; w++) begin
         way_hit[w] = ent_q[w].valid && (ent_q[w].tag == lookup_tag_i);
      end
   end

   assign hit_o     = |way_hit;
   assign hit_way_o = way_hit[1];

   // Fill an empty way first, otherwise follow LRU
   assign victim_way_o = !ent_q[0].valid ? 1'b0 :
                         !ent_q[1].valid ? 1'b1 : lru_rd_q;

endmodule

`default_nettype wire

//--- rtl/dcache_top.sv
`default_nettype none

module dcache_top import dcache_pkg::*; (
   input  wire logic                    clk,
   input  wire logic                    rst,
   // CPU port
   input  wire logic                    cpu_req_i,
   input  wire cpu_req_t                cpu_i,
   output logic                         cpu_ack_o,
   output logic [DATA_W-1:0]            cpu_rdata_o,
   // Memory port
   output logic                         mem_req_o,
   output mem_req_t                     mem_o,
   input  wire logic                    mem_ack_i,
   input  wire logic [DATA_W-1:0]       mem_rdata_i,
   // Configuration bus
   input  wire logic                    cfg_req_i,
   input  wire logic                    cfg_we_i,
   input  wire logic [CFG_ADDR_W-1:0]   cfg_addr_i,
   input  wire cfg_wdata_u              cfg_wdata_i,
   output logic                         cfg_ack_o,
   output logic [DATA_W-1:0]            cfg_rdata_o
);

   // Register block to controller
   logic                    enable;
   logic                    inval_req;
   logic [INDEX_W-1:0]      inval_index;
   logic                    inval_ack;

   // Tag store
   logic                    hit;
   logic                    hit_way;
   logic                    victim_way;
   logic                    tag_wr_en;
   logic [INDEX_W-1:0]      tag_wr_index;
   logic                    tag_wr_way;
   tag_entry_t              tag_wr_entry;
   logic                    tag_inval;
   logic                    lru_touch;
   logic                    lru_way;

   // Data store
   logic                    ds_wr_en;
   logic                    ds_wr_way;
   logic [WORD_OFS_W-1:0]   ds_wr_word;
   logic [DATA_W-1:0]       ds_wr_data;
   logic [BSEL_W-1:0]       ds_wr_bsel;
   logic [DATA_W-1:0]       store_rdata;

   dcache_cfg_regs u_cfg_regs (
      .clk           (clk),
      .rst           (rst),
      .cfg_req_i     (cfg_req_i),
      .cfg_we_i      (cfg_we_i),
      .cfg_addr_i    (cfg_addr_i),
      .cfg_wdata_i   (cfg_wdata_i),
      .cfg_ack_o     (cfg_ack_o),
      .cfg_rdata_o   (cfg_rdata_o),
      .enable_o      (enable),
      .inval_req_o   (inval_req),
      .inval_index_o (inval_index),
      .inval_ack_i   (inval_ack)
   );

   dcache_ctrl u_ctrl (
      .clk            (clk),
      .rst            (rst),
      .cpu_req_i      (cpu_req_i),
      .cpu_i          (cpu_i),
      .cpu_ack_o      (cpu_ack_o),
      .cpu_rdata_o    (cpu_rdata_o),
      .mem_req_o      (mem_req_o),
      .mem_o          (mem_o),
      .mem_ack_i      (mem_ack_i),
      .mem_rdata_i    (mem_rdata_i),
      .enable_i       (enable),
      .inval_req_i    (inval_req),
      .inval_index_i  (inval_index),
      .inval_ack_o    (inval_ack),
      .hit_i          (hit),
      .hit_way_i      (hit_way),
      .victim_way_i   (victim_way),
      .tag_wr_en_o    (tag_wr_en),
      .tag_wr_index_o (tag_wr_index),
      .tag_wr_way_o   (tag_wr_way),
      .tag_wr_entry_o (tag_wr_entry),
      .tag_inval_o    (tag_inval),
      .lru_touch_o    (lru_touch),
      .lru_way_o      (lru_way),
      .ds_wr_en_o     (ds_wr_en),
      .ds_wr_way_o    (ds_wr_way),
      .ds_wr_word_o   (ds_wr_word),
      .ds_wr_data_o   (ds_wr_data),
      .ds_wr_bsel_o   (ds_wr_bsel),
      .store_rdata_i  (store_rdata)
   );

   // Both stores read the set of the current CPU request
   dcache_tag_store u_tag_store (
      .clk          (clk),
      .rst          (rst),
      .rd_index_i   (cpu_i.addr.index),
      .wr_en_i      (tag_wr_en),
      .wr_index_i   (tag_wr_index),
      .wr_way_i     (tag_wr_way),
      .wr_entry_i   (tag_wr_entry),
      .inval_i      (tag_inval),
      .lru_touch_i  (lru_touch),
      .lru_way_i    (lru_way),
      .lookup_tag_i (cpu_i.addr.tag),
      .hit_o        (hit),
      .hit_way_o    (hit_way),
      .victim_way_o (victim_way)
   );

   dcache_data_store u_data_store (
      .clk        (clk),
      .rd_index_i (cpu_i.addr.index),
      .rd_word_i  (cpu_i.addr.word),
      .rd_way_i   (hit_way),
      .wr_en_i    (ds_wr_en),
      .wr_way_i   (ds_wr_way),
      .wr_index_i (cpu_i.addr.index),
      .wr_word_i  (ds_wr_word),
      .wr_data_i  (ds_wr_data),
      .wr_bsel_i  (ds_wr_bsel),
      .rdata_o    (store_rdata)
   );

endmodule

`default_nettype wire

//--- vlog.f
rtl/dcache_pkg.sv
rtl/dcache_tag_store.sv
rtl/dcache_data_store.sv
rtl/dcache_ctrl.sv
rtl/dcache_cfg_regs.sv
rtl/dcache_top.sv
dv/dcache_chk.sv
dv/dcache_tb.sv
